// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_port_ingress
FILELIST  = compile.f
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
source/switch_pkg.sv
source/port_wr_frontend.sv
source/sram_matcher.sv
source/port_wr_backend.sv
source/port_ingress_top.sv
verification/tb_clock_gen.sv
verification/ingress_checker.sv
verification/tb_port_ingress.sv

// File: source/port_ingress_top.sv
`timescale 1ns/1ps
`default_nettype none

module port_ingress_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // packet input
    input  wire logic                   wr_sop,
    input  wire logic                   wr_eop,
    input  wire logic                   wr_vld,
    input  wire switch_pkg::pkt_word_u  wr_data,
    output logic                        pause,
    // space returned by the switch
    input  wire logic                   rel_valid,
    input  wire switch_pkg::release_t   rel,
    // SRAM write port
    output logic                        sram_wr_en,
    output switch_pkg::sram_wr_t        sram_wr,
    // descriptor out
    output logic                        desc_valid,
    input  wire logic                   desc_ready,
    output switch_pkg::pkt_desc_t       desc
);

    logic                               match_enable;
    switch_pkg::match_req_t             match_req;
    logic                               match_suc;
    logic [switch_pkg::bank_id_w-1:0]   match_bank;
    logic                               slot_busy;
    logic                               ready_to_xfer;
    logic                               xfer_data_vld;
    logic [switch_pkg::word_w-1:0]      xfer_data;
    logic                               end_of_packet;

    port_wr_frontend u_frontend (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_sop        (wr_sop),
        .wr_eop        (wr_eop),
        .wr_vld        (wr_vld),
        .wr_data       (wr_data),
        .pause         (pause),
        .match_enable  (match_enable),
        .match_req     (match_req),
        .match_suc     (match_suc),
        .ready_to_xfer (ready_to_xfer),
        .xfer_data_vld (xfer_data_vld),
        .xfer_data     (xfer_data),
        .end_of_packet (end_of_packet)
    );

    sram_matcher u_matcher (
        .clk          (clk),
        .rst_n        (rst_n),
        .match_enable (match_enable),
        .match_req    (match_req),
        .slot_busy    (slot_busy),
        .match_suc    (match_suc),
        .match_bank   (match_bank),
        .rel_valid    (rel_valid),
        .rel          (rel)
    );

    port_wr_backend u_backend (
        .clk           (clk),
        .rst_n         (rst_n),
        .match_suc     (match_suc),
        .match_bank    (match_bank),
        .match_req     (match_req),
        .ready_to_xfer (ready_to_xfer),
        .xfer_data_vld (xfer_data_vld),
        .end_of_packet (end_of_packet),
        .xfer_data     (xfer_data),
        .slot_busy     (slot_busy),
        .sram_wr_en    (sram_wr_en),
        .sram_wr       (sram_wr),
        .desc_valid    (desc_valid),
        .desc_ready    (desc_ready),
        .desc          (desc)
    );

endmodule

`default_nettype wire

// File: source/port_wr_backend.sv
`timescale 1ns/1ps
`default_nettype none

module port_wr_backend (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            match_suc,
    input  wire logic [switch_pkg::bank_id_w-1:0] match_bank,
    input  wire switch_pkg::match_req_t          match_req,
    input  wire logic                            ready_to_xfer,
    input  wire logic                            xfer_data_vld,
    input  wire logic                            end_of_packet,
    input  wire logic [switch_pkg::word_w-1:0]   xfer_data,
    output logic                                 slot_busy,
    output logic                                 sram_wr_en,
    output switch_pkg::sram_wr_t                 sram_wr,
    output logic                                 desc_valid,
    input  wire logic                            desc_ready,
    output switch_pkg::pkt_desc_t                desc
);

    logic [switch_pkg::bank_id_w-1:0]   g_bank;      // granted bank, held until transfer starts
    switch_pkg::match_req_t             g_req;
    logic                               grant_held;
    logic [switch_pkg::bank_id_w-1:0]   cur_bank;    // bank of the packet being written
    logic                               in_pkt;

    logic [switch_pkg::bank_addr_w-1:0] bank_ptr [switch_pkg::num_banks];  // next free address

    logic                               wr_vld_q;
    logic                               eop_q;
    logic [switch_pkg::word_w-1:0]      data_q;

    // grant capture
    always_ff @(posedge clk) begin
        if (match_suc) begin
            g_bank <= match_bank;
            g_req  <= match_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_held <= 1'b0;
        end else if (match_suc) begin
            grant_held <= 1'b1;
        end else if (ready_to_xfer) begin
            grant_held <= 1'b0;
        end
    end

    // busy from transfer start until the last write has gone out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
        end else if (ready_to_xfer) begin
            in_pkt <= 1'b1;
        end else if (wr_vld_q && eop_q) begin
            in_pkt <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_to_xfer) cur_bank <= g_bank;
    end

    // extra register stage in front of the SRAM port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_vld_q <= 1'b0;
            eop_q    <= 1'b0;
        end else begin
            wr_vld_q <= xfer_data_vld;
            eop_q    <= end_of_packet;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= xfer_data;
    end

    // pointers wrap inside the bank by their width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < switch_pkg::num_banks; b++) bank_ptr[b] <= '0;
        end else if (wr_vld_q) begin
            bank_ptr[cur_bank] <= bank_ptr[cur_bank] + 1'b1;
        end
    end

    assign sram_wr_en = wr_vld_q;

    always_comb begin
        sram_wr.bank = cur_bank;
        sram_wr.addr = bank_ptr[cur_bank];
        sram_wr.data = data_q;
    end

    // descriptor slot, one entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            desc_valid <= 1'b0;
        end else if (ready_to_xfer) begin
            desc_valid <= 1'b1;
        end else if (desc_ready) begin
            desc_valid <= 1'b0;  // handshake empties the slot
        end
    end

    always_ff @(posedge clk) begin
        if (ready_to_xfer) begin
            desc.dest_port  <= g_req.dest_port;
            desc.bank       <= g_bank;
            desc.start_addr <= bank_ptr[g_bank];  // stable, previous packet is done
            desc.length     <= g_req.length;
        end
    end

    assign slot_busy = grant_held || in_pkt || desc_valid;

    // frontend only sends after a grant was taken over here
    a_data_granted: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_data_vld |-> in_pkt);

endmodule

`default_nettype wire

// File: source/port_wr_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module port_wr_frontend (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         wr_sop,
    input  wire logic                         wr_eop,
    input  wire logic                         wr_vld,
    input  wire switch_pkg::pkt_word_u        wr_data,
    output logic                              pause,
    output logic                              match_enable,
    output switch_pkg::match_req_t            match_req,
    input  wire logic                         match_suc,
    output logic                              ready_to_xfer,
    output logic                              xfer_data_vld,
    output logic [switch_pkg::word_w-1:0]     xfer_data,
    output logic                              end_of_packet
);

    typedef enum logic [1:0] {
        wr_idle,     // waiting for sop
        wr_hdr_due,  // sop seen, next halfword is the header
        wr_writing,  // body halfwords coming in
        wr_done      // all halfwords in, waiting for eop
    } wr_state_t;

    typedef enum logic [1:0] {
        x_idle,
        x_send,
        x_stall      // packet granted but buffer ran dry
    } xfer_state_t;

    wr_state_t   wr_state;
    xfer_state_t xfer_state;

    logic [switch_pkg::word_w-1:0] fifo_mem [switch_pkg::fifo_depth];

    // one extra bit on each pointer tells full from empty
    logic [switch_pkg::fifo_addr_w:0] wr_ptr;
    logic [switch_pkg::fifo_addr_w:0] rd_ptr;
    logic [switch_pkg::fifo_addr_w:0] fill;
    logic                             fifo_empty;
    logic                             fifo_rd;
    logic                             hdr_write;

    logic [switch_pkg::pkt_len_w-1:0] wr_cnt;     // halfwords of current packet so far
    logic [switch_pkg::pkt_len_w-1:0] xfer_left;  // halfwords still to send
    logic [switch_pkg::pkt_len_w-1:0] pend_len;   // length of the granted packet
    logic                             grant_pend; // grant kept until transfer can start

    assign fill       = wr_ptr - rd_ptr;
    assign fifo_empty = (fill == '0);
    assign fifo_rd    = (xfer_state == x_send) && !fifo_empty;
    assign hdr_write  = (wr_state == wr_hdr_due) && wr_vld;

    // buffer write, same cycle as wr_vld
    always_ff @(posedge clk) begin
        if (wr_vld) begin
            fifo_mem[wr_ptr[switch_pkg::fifo_addr_w-1:0]] <= wr_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_vld) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // write machine
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                wr_idle: if (wr_sop) wr_state <= wr_hdr_due;
                wr_hdr_due: begin
                    if (wr_vld) begin
                        wr_cnt   <= 9'd1;       // header counts as one
                        wr_state <= wr_writing;
                    end
                end
                wr_writing: begin
                    if (wr_vld) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt + 1'b1 == match_req.length) wr_state <= wr_done;
                    end
                end
                default: if (wr_eop) wr_state <= wr_idle;
            endcase
        end
    end

    // header seen through the union view, only on the first halfword
    always_ff @(posedge clk) begin
        if (hdr_write) begin
            match_req.dest_port <= wr_data.hdr.dest_port;
            match_req.length    <= wr_data.hdr.length;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_enable <= 1'b0;
        end else if (hdr_write) begin
            match_enable <= 1'b1;  // request goes out the cycle after the header
        end else if (match_suc) begin
            match_enable <= 1'b0;
        end
    end

    // grant may land while the previous packet still drains
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_pend <= 1'b0;
        end else if (match_suc) begin
            grant_pend <= 1'b1;
        end else if (ready_to_xfer) begin
            grant_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (match_suc) pend_len <= match_req.length;
    end

    assign ready_to_xfer = (xfer_state == x_idle) && grant_pend;

    // transfer machine
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xfer_state <= x_idle;
            xfer_left  <= '0;
        end else begin
            case (xfer_state)
                x_idle: begin
                    if (grant_pend) begin
                        xfer_left  <= pend_len;
                        xfer_state <= x_send;
                    end
                end
                x_send: begin
                    if (fifo_rd) begin
                        xfer_left <= xfer_left - 1'b1;
                        if (xfer_left == 9'd1) xfer_state <= x_idle;  // last one read
                    end else begin
                        xfer_state <= x_stall;
                    end
                end
                default: if (!fifo_empty) xfer_state <= x_send;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr        <= '0;
            xfer_data_vld <= 1'b0;
            end_of_packet <= 1'b0;
        end else begin
            xfer_data_vld <= fifo_rd;
            end_of_packet <= fifo_rd && (xfer_left == 9'd1);
            if (fifo_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) xfer_data <= fifo_mem[rd_ptr[switch_pkg::fifo_addr_w-1:0]];
    end

    // registered, so the source sees it a cycle late and needs two more to stop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause <= 1'b0;
        end else begin
            pause <= ((fill + {{switch_pkg::fifo_addr_w{1'b0}}, wr_vld})
                        >= (switch_pkg::fifo_depth - switch_pkg::pause_margin))
                  || (match_enable && !match_suc);  // packet still waiting for a bank
        end
    end

    // source must have honored pause in time
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld |-> fill < switch_pkg::fifo_depth);

    // a whole packet always fits the buffer
    a_pkt_len: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_write |-> wr_data.hdr.length <= switch_pkg::max_pkt_len);

endmodule

`default_nettype wire

// File: source/sram_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module sram_matcher (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            match_enable,
    input  wire switch_pkg::match_req_t          match_req,
    input  wire logic                            slot_busy,
    output logic                                 match_suc,
    output logic [switch_pkg::bank_id_w-1:0]     match_bank,
    input  wire logic                            rel_valid,
    input  wire switch_pkg::release_t            rel
);

    logic [switch_pkg::pkt_len_w-1:0]      free_cnt [switch_pkg::num_banks];
    // room for under/overflow
    logic signed [switch_pkg::pkt_len_w+1:0] free_nxt [switch_pkg::num_banks];
    logic [switch_pkg::bank_id_w-1:0]      best;
    logic                                  grant;

    // most free space wins and a tie goes to the lowest index
    always_comb begin
        best = '0;
        for (int b = 1; b < switch_pkg::num_banks; b++) begin
            if (free_cnt[b] > free_cnt[best]) best = b[switch_pkg::bank_id_w-1:0];
        end
    end

    // !match_suc keeps a still-high match_enable from granting twice
    assign grant = match_enable && !match_suc && !slot_busy
                && (free_cnt[best] >= match_req.length);

    // reserve and release can hit the same bank in one cycle
    always_comb begin
        for (int b = 0; b < switch_pkg::num_banks; b++) begin
            free_nxt[b] = $signed({2'b00, free_cnt[b]});
            if (grant && best == b) begin
                free_nxt[b] = free_nxt[b] - $signed({2'b00, match_req.length});
            end
            if (rel_valid && rel.bank == b) begin
                free_nxt[b] = free_nxt[b] + $signed({2'b00, rel.length});
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_suc <= 1'b0;
            for (int b = 0; b < switch_pkg::num_banks; b++) begin
                free_cnt[b] <= switch_pkg::pkt_len_w'(switch_pkg::bank_depth);  // all free
            end
        end else begin
            match_suc <= grant;  // one-cycle pulse
            for (int b = 0; b < switch_pkg::num_banks; b++) begin
                free_cnt[b] <= free_nxt[b][switch_pkg::pkt_len_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) match_bank <= best;
    end

    // releases from outside must match what was reserved
    for (genvar g = 0; g < switch_pkg::num_banks; g++) begin : g_free_chk
        a_free_range: assert property (@(posedge clk) disable iff (!rst_n)
            free_nxt[g] >= 0 && free_nxt[g] <= switch_pkg::bank_depth);
    end

    // backend slot has to be empty for every grant
    a_grant_slot: assert property (@(posedge clk) disable iff (!rst_n)
        match_suc |-> !slot_busy);

endmodule

`default_nettype wire

// File: source/switch_pkg.sv
`default_nettype none

package switch_pkg;

    localparam int num_banks    = 4;
    localparam int bank_depth   = 256;  // halfwords per bank
    localparam int bank_addr_w  = 8;
    localparam int bank_id_w    = 2;
    localparam int fifo_depth   = 64;
    localparam int fifo_addr_w  = 6;
    localparam int max_pkt_len  = 64;   // header included
    localparam int pkt_len_w    = 9;
    localparam int word_w       = 16;
    localparam int pause_margin = 3;    // free entries left when pause goes up

    // first halfword of every packet
    typedef struct packed {
        logic [pkt_len_w-1:0] length;   // in halfwords, header counted
        logic [2:0]           rsvd;     // ignored
        logic [3:0]           dest_port;
    } pkt_header_t;

    // an input halfword, seen either as payload or as the header
    typedef union packed {
        logic [word_w-1:0] raw;
        pkt_header_t       hdr;
    } pkt_word_u;

    typedef struct packed {
        logic [3:0]           dest_port;
        logic [pkt_len_w-1:0] length;
    } match_req_t;

    typedef struct packed {
        logic [3:0]             dest_port;
        logic [bank_id_w-1:0]   bank;
        logic [bank_addr_w-1:0] start_addr;
        logic [pkt_len_w-1:0]   length;
    } pkt_desc_t;

    typedef struct packed {
        logic [bank_id_w-1:0]   bank;
        logic [bank_addr_w-1:0] addr;
        logic [word_w-1:0]      data;
    } sram_wr_t;

    // space handed back by the switch
    typedef struct packed {
        logic [bank_id_w-1:0] bank;
        logic [pkt_len_w-1:0] length;
    } release_t;

endpackage

`default_nettype wire

// File: verification/ingress_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_checker (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wr_sop,
    input  wire logic                  wr_vld,
    input  wire switch_pkg::pkt_word_u wr_data,
    input  wire logic                  pause,
    input  wire logic                  rel_valid,
    input  wire switch_pkg::release_t  rel,
    input  wire logic                  sram_wr_en,
    input  wire switch_pkg::sram_wr_t  sram_wr,
    input  wire logic                  desc_valid,
    input  wire logic                  desc_ready,
    input  wire switch_pkg::pkt_desc_t desc,
    input  int                         test_id,
    input  wire logic                  quiet,       // no descriptor or write allowed now
    output logic                       pending,     // input seen but not yet written out
    output int                         mismatch_cnt,
    output int                         other_cnt
);

    int free_model [4];   // own view of free space per bank
    int ptr_model  [4];   // own view of next write address per bank
    switch_pkg::pkt_header_t hdr_q [$];
    logic [15:0]             data_q [$];   // every input halfword in order
    logic                    hdr_next;
    logic                    slot_seen;    // current descriptor already checked
    switch_pkg::pkt_desc_t   desc_hold;
    switch_pkg::pkt_desc_t   exp_desc;
    switch_pkg::sram_wr_t    exp_wr;
    switch_pkg::pkt_header_t hdr;
    int                      bank;
    int                      wr_bank;
    int                      wr_addr;
    int                      wr_left;
    int                      wait_cyc;     // cycles a header has waited with no bank free

    initial begin
        mismatch_cnt = 0;
        other_cnt    = 0;
        pending      = 1'b0;
    end

    function automatic string test_label(input int id);
        case (id)
            1:       return "single_packet";
            2:       return "bank_choice";
            3:       return "back_to_back";
            4:       return "desc_backpressure";
            5:       return "all_banks_full";
            default: return "startup";
        endcase
    endfunction

    // expected bank by most free space and lowest index on a tie or -1 if nothing fits
    function automatic int expected_bank(input int len);
        int best;
        best = 0;
        for (int b = 1; b < 4; b++) begin
            if (free_model[b] > free_model[best]) best = b;
        end
        if (free_model[best] < len) return -1;
        return best;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < 4; b++) begin
                free_model[b] = 256;
                ptr_model[b]  = 0;
            end
            hdr_q.delete();
            data_q.delete();
            hdr_next  = 1'b0;
            slot_seen = 1'b0;
            wr_left   = 0;
            wait_cyc  = 0;
        end else begin
            if (wr_sop) hdr_next = 1'b1;
            if (wr_vld) begin
                data_q.push_back(wr_data.raw);
                if (hdr_next) begin
                    hdr_q.push_back(wr_data.hdr);  // first halfword is the header
                    hdr_next = 1'b0;
                end
            end
            if (rel_valid) free_model[rel.bank] += rel.length;

            // new descriptor in the slot
            if (desc_valid && !slot_seen) begin
                if (quiet) begin
                    $display("error %s: descriptor appeared while no bank had room",
                             test_label(test_id));
                    other_cnt++;
                end
                if (hdr_q.size() == 0) begin
                    $display("error %s: descriptor without any packet sent",
                             test_label(test_id));
                    other_cnt++;
                end else begin
                    hdr  = hdr_q.pop_front();
                    bank = expected_bank(hdr.length);
                    if (bank < 0) begin
                        $display("error %s: descriptor although no bank fits length %0d",
                                 test_label(test_id), hdr.length);
                        other_cnt++;
                        bank = desc.bank;  // follow the DUT to keep checking data
                    end
                    exp_desc.dest_port  = hdr.dest_port;
                    exp_desc.bank       = bank[1:0];
                    exp_desc.start_addr = ptr_model[bank][7:0];
                    exp_desc.length     = hdr.length;
                    if (desc !== exp_desc) begin
                        $display("mismatch %s desc: expected %h actual %h",
                                 test_label(test_id), exp_desc, desc);
                        mismatch_cnt++;
                    end
                    free_model[bank] -= hdr.length;
                    wr_bank = bank;
                    wr_addr = ptr_model[bank];
                    wr_left = hdr.length;
                    ptr_model[bank] = (ptr_model[bank] + hdr.length) % 256;  // wraps in bank
                end
                slot_seen = 1'b1;
                desc_hold = desc;
            end else if (desc_valid && desc !== desc_hold) begin
                $display("mismatch %s desc held: expected %h actual %h",
                         test_label(test_id), desc_hold, desc);
                mismatch_cnt++;
            end
            if (desc_valid && desc_ready) slot_seen = 1'b0;  // handshake

            if (sram_wr_en) begin
                if (quiet) begin
                    $display("error %s: SRAM write while no bank had room",
                             test_label(test_id));
                    other_cnt++;
                end
                if (wr_left == 0 || data_q.size() == 0) begin
                    $display("error %s: SRAM write with no halfword expected",
                             test_label(test_id));
                    other_cnt++;
                end else begin
                    exp_wr.bank = wr_bank[1:0];
                    exp_wr.addr = wr_addr[7:0];
                    exp_wr.data = data_q.pop_front();
                    if (sram_wr !== exp_wr) begin
                        $display("mismatch %s sram_wr: expected %h actual %h",
                                 test_label(test_id), exp_wr, sram_wr);
                        mismatch_cnt++;
                    end
                    wr_addr = (wr_addr + 1) % 256;
                    wr_left--;
                end
            end

            // a packet buffered but unmatched keeps pause up
            if (quiet && hdr_q.size() != 0) begin
                if (wait_cyc >= 2 && pause !== 1'b1) begin
                    $display("mismatch %s pause: expected 1 actual %b",
                             test_label(test_id), pause);
                    mismatch_cnt++;
                end
                wait_cyc++;
            end else begin
                wait_cyc = 0;
            end
        end
        pending = (hdr_q.size() != 0) || (data_q.size() != 0) || (wr_left != 0);
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int period_ns    = 100;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release 1 ns after an edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/tb_port_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module tb_port_ingress;

    localparam int total_pkts     = 32;                      // 1 + 6 + 6 + 2 + 16 + 1
    localparam int timeout_cycles = 200 * total_pkts + 1000;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_sop;
    logic                  wr_eop;
    logic                  wr_vld;
    switch_pkg::pkt_word_u wr_data;
    logic                  pause;
    logic                  rel_valid;
    switch_pkg::release_t  rel;
    logic                  sram_wr_en;
    switch_pkg::sram_wr_t  sram_wr;
    logic                  desc_valid;
    logic                  desc_ready;
    switch_pkg::pkt_desc_t desc;

    int   seed = 32'h12e5_5b74;
    int   used [4];        // space taken per bank so releases stay legal
    int   cycle_cnt;
    int   test_id;
    logic quiet;
    logic hold_ready;
    logic pending;
    int   mismatch_cnt;
    int   other_cnt;

    tb_clock_gen clk_gen (.clk(clk), .rst_n(rst_n));

    port_ingress_top UUT (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data), .pause(pause),
        .rel_valid(rel_valid), .rel(rel),
        .sram_wr_en(sram_wr_en), .sram_wr(sram_wr),
        .desc_valid(desc_valid), .desc_ready(desc_ready), .desc(desc)
    );

    ingress_checker chk (
        .clk(clk), .rst_n(rst_n), .wr_sop(wr_sop), .wr_vld(wr_vld), .wr_data(wr_data),
        .pause(pause),
        .rel_valid(rel_valid), .rel(rel), .sram_wr_en(sram_wr_en), .sram_wr(sram_wr),
        .desc_valid(desc_valid), .desc_ready(desc_ready), .desc(desc),
        .test_id(test_id), .quiet(quiet), .pending(pending),
        .mismatch_cnt(mismatch_cnt), .other_cnt(other_cnt)
    );

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    // sop, halfwords honoring pause with random gaps, then eop
    task automatic send_packet(input int len, input logic [3:0] dest);
        switch_pkg::pkt_word_u word;
        int i;
        wr_sop = 1'b1;
        @(posedge clk); #1;
        wr_sop = 1'b0;
        i = 0;
        while (i < len) begin
            if (pause || rand_range(0, 7) == 0) begin
                wr_vld = 1'b0;
            end else begin
                if (i == 0) begin
                    word.hdr.length    = len[8:0];
                    word.hdr.rsvd      = rand_range(0, 7);
                    word.hdr.dest_port = dest;
                end else begin
                    word.raw = rand_range(0, 16'hffff);
                end
                wr_data = word;
                wr_vld  = 1'b1;
                i++;
            end
            @(posedge clk); #1;
        end
        wr_vld = 1'b0;
        wr_eop = 1'b1;
        @(posedge clk); #1;
        wr_eop = 1'b0;
    endtask

    task automatic send_random(input int lo, input int hi);
        send_packet(rand_range(lo, hi), rand_range(0, 15));
    endtask

    task automatic wait_idle();
        @(posedge clk); #1;
        while (pending || desc_valid) begin
            @(posedge clk); #1;
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic release_space(input int bank, input int len);
        rel_valid   = 1'b1;
        rel.bank    = bank[1:0];
        rel.length  = len[8:0];
        used[bank] -= len;
        @(posedge clk); #1;
        rel_valid = 1'b0;
    endtask

    // ready with random gaps unless held low
    always @(posedge clk) begin
        #1;
        desc_ready = hold_ready ? 1'b0 : (rand_range(0, 3) != 0);
    end

    always @(posedge clk) begin
        if (desc_valid && desc_ready) used[desc.bank] += desc.length;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run still busy after %0d cycles", timeout_cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        wr_sop     = 1'b0;
        wr_eop     = 1'b0;
        wr_vld     = 1'b0;
        wr_data    = '0;
        rel_valid  = 1'b0;
        rel        = '0;
        desc_ready = 1'b0;
        hold_ready = 1'b0;
        quiet      = 1'b0;
        test_id    = 0;
        cycle_cnt  = 0;
        for (int b = 0; b < 4; b++) used[b] = 0;
        wait (rst_n);
        @(posedge clk); #1;

        test_id = 1;                     // one packet with its data and descriptor
        send_random(2, 64);
        wait_idle();

        test_id = 2;                     // bank rule over grants and releases
        for (int n = 0; n < 6; n++) begin
            send_random(2, 64);
            wait_idle();
            bank_rel: begin
                int b;
                b = rand_range(0, 3);
                if (used[b] > 0) release_space(b, rand_range(1, used[b]));
            end
        end

        test_id = 3;                     // long packets back to back with pause active
        for (int n = 0; n < 6; n++) send_random(48, 64);
        wait_idle();

        test_id = 4;                     // slot held full
        hold_ready = 1'b1;
        fork
            begin
                send_random(2, 64);
                send_random(2, 64);
            end
            begin
                wait (desc_valid);
                repeat (200) @(posedge clk);
                #1;
                hold_ready = 1'b0;
            end
        join
        wait_idle();

        test_id = 5;                     // empty all banks and then fill them
        for (int b = 0; b < 4; b++) begin
            if (used[b] > 0) release_space(b, used[b]);
        end
        for (int n = 0; n < 16; n++) send_packet(64, rand_range(0, 15));
        wait_idle();
        quiet = 1'b1;
        fork
            send_random(2, 64);
            begin
                repeat (300) @(posedge clk);
                #1;
                quiet = 1'b0;
                release_space(rand_range(0, 3), 64);
            end
        join
        wait_idle();

        repeat (10) @(posedge clk);
        $display("closing report: %0d mismatch errors, %0d other errors",
                 mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
